/* src/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// fetch address out of reset
// first instruction lives at byte 44
`define RV_RESET_PC 32'd44

// single interrupt handler entry point
`define RV_TRAP_PC 32'd0

// integer register width
`define RV_XLEN 64

// architectural register count, x0 included
`define RV_NREGS 32

// console byte goes out in the low 8 bits
// upper bits of the bus word are zero
`define RV_BYTE_W 8

`endif

/* src/rv_pkg.sv */
package rv_pkg;

    // data path word
    typedef logic [63:0] word_t;

    // instruction address, byte granular
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // register index
    typedef logic [4:0] reg_idx_t;

    // major opcode field, bits 6:0
    typedef logic [6:0] opcode_t;

    // what execute does with the word in ir
    typedef enum logic [2:0] {
        OP_NOP,
        OP_LUI,
        OP_ADDI,
        OP_SB,
        OP_MRET
    } op_kind_t;

    // major opcodes in use
    localparam opcode_t OPC_LUI   = 7'b0110111;
    localparam opcode_t OPC_OPIMM = 7'b0010011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // funct3 for addi and sb
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_SB   = 3'b000;

    // mret is matched on the whole word
    localparam instr_t MRET_WORD = 32'h30200073;

    // addi x0, x0, 0
    localparam instr_t NOP_WORD = 32'h00000013;

endpackage

/* src/rv_decode.sv */
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
    input  instr_t   ir,
    output op_kind_t kind,
    output reg_idx_t rd,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output word_t    imm_u,
    output word_t    imm_i,
    output word_t    imm_s
);

    opcode_t    opcode;
    logic [2:0] funct3;

    // fixed field positions
    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];

    // register indices, always extracted
    // rd 0 is left alone here, regfile drops the write
    assign rd  = ir[11:7];
    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];

    // u-type, upper 20 bits then sign extend from bit 31
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};

    // i-type, 12 bit signed
    assign imm_i = {{52{ir[31]}}, ir[31:20]};

    // s-type, split immediate
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};

    // classify
    always_comb begin
        kind = OP_NOP;
        if (ir == MRET_WORD) begin
            // full word match, opcode alone is SYSTEM
            kind = OP_MRET;
        end else begin
            case (opcode)
                OPC_LUI: begin
                    kind = OP_LUI;
                end
                OPC_OPIMM: begin
                    // other op-imm funct3 values fall to nop
                    if (funct3 == F3_ADDI) begin
                        kind = OP_ADDI;
                    end
                end
                OPC_STORE: begin
                    // only byte store
                    if (funct3 == F3_SB) begin
                        kind = OP_SB;
                    end
                end
                default: begin
                    kind = OP_NOP;
                end
            endcase
        end
    end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    input  reg_idx_t dbg_idx,
    output word_t    rdata_a,
    output word_t    rdata_b,
    output word_t    dbg_data
);

    // register array
    word_t regs [`RV_NREGS];

    // single write port
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // reads are combinational
    // x0 forced to zero regardless of array contents
    assign rdata_a = (raddr_a == '0) ? {`RV_XLEN{1'b0}} : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? {`RV_XLEN{1'b0}} : regs[raddr_b];

    // debug read, same rule for x0
    assign dbg_data = (dbg_idx == '0) ? {`RV_XLEN{1'b0}} : regs[dbg_idx];

endmodule

/* src/rv_trap_unit.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_trap_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  irq,
    input  logic  mret,
    input  addr_t ir_pc,
    output logic  take,
    output logic  redirect,
    output addr_t target,
    output logic  in_handler
);

    // return address of the interrupted instruction
    addr_t mepc;

    // entry when the level is up and no handler is running
    // in_handler doubles as the pending flag
    assign take = irq && !in_handler;

    // either event moves the pc
    assign redirect = take || mret;

    // entry wins over a simultaneous mret
    assign target = (mret && !take) ? mepc : `RV_TRAP_PC;

    // handler state
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            in_handler <= 1'b0;
        end else if (take) begin
            in_handler <= 1'b1;
        end else if (mret) begin
            // reopen for the next interrupt
            in_handler <= 1'b0;
        end
    end

    // mepc loads on entry only
    always_ff @(posedge clk) begin
        if (take) begin
            // instruction in ir is dropped and will be refetched from here
            // an mret caught in the same edge is recorded instead
            mepc <= ir_pc;
        end
    end

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  instr_t   instruction,
    input  logic     irq,
    input  reg_idx_t dbg_idx,
    output addr_t    pc,
    output word_t    bus_address,
    output word_t    bus_write_data,
    output logic     bus_write_enable,
    output word_t    dbg_data
);

    // fetch register and its address
    instr_t ir;
    addr_t  ir_pc;
    // squash flag for the wrong-path fetch after a redirect
    logic   bubble;

    // decode outputs
    op_kind_t kind;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm_u;
    word_t    imm_i;
    word_t    imm_s;

    // register file
    word_t rs1_val;
    word_t rs2_val;
    logic  rf_we;
    word_t rf_wdata;

    // trap unit
    logic  trap_irq;
    logic  take;
    logic  redirect;
    addr_t target;
    logic  mret_exec;

    // execute enable
    logic  exec_valid;

    rv_decode u_rv_decode (
        .ir    (ir),
        .kind  (kind),
        .rd    (rd),
        .rs1   (rs1),
        .rs2   (rs2),
        .imm_u (imm_u),
        .imm_i (imm_i),
        .imm_s (imm_s)
    );

    rv_regfile u_rv_regfile (
        .clk      (clk),
        .reset    (reset),
        .we       (rf_we),
        .waddr    (rd),
        .wdata    (rf_wdata),
        .raddr_a  (rs1),
        .raddr_b  (rs2),
        .dbg_idx  (dbg_idx),
        .rdata_a  (rs1_val),
        .rdata_b  (rs2_val),
        .dbg_data (dbg_data)
    );

    // hold off entry during a bubble
    // the squashed word's address must never land in mepc
    assign trap_irq = irq && !bubble;

    rv_trap_unit u_rv_trap_unit (
        .clk        (clk),
        .reset      (reset),
        .irq        (trap_irq),
        .mret       (mret_exec),
        .ir_pc      (ir_pc),
        .take       (take),
        .redirect   (redirect),
        .target     (target),
        .in_handler ()
    );

    // ir executes unless squashed or displaced by an interrupt
    assign exec_valid = !bubble && !take;

    // register writes for lui and addi
    assign rf_we    = exec_valid && ((kind == OP_LUI) || (kind == OP_ADDI));
    assign rf_wdata = (kind == OP_LUI) ? imm_u : (rs1_val + imm_i);

    // mret only counts when it really executes
    assign mret_exec = exec_valid && (kind == OP_MRET);

    // fetch register, pc and bubble
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc     <= `RV_RESET_PC;
            ir     <= NOP_WORD;
            ir_pc  <= `RV_RESET_PC;
            bubble <= 1'b0;
        end else begin
            ir    <= instruction;
            ir_pc <= pc;
            if (redirect) begin
                // trap entry or return makes the next fetched word wrong path
                pc     <= target;
                bubble <= 1'b1;
            end else begin
                pc     <= pc + 32'd4;
                bubble <= 1'b0;
            end
        end
    end

    // one bus strobe pulse per executed sb
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus_write_enable <= 1'b0;
        end else begin
            bus_write_enable <= exec_valid && (kind == OP_SB);
        end
    end

    // bus payload loads with each executed sb
    always_ff @(posedge clk) begin
        if (exec_valid && (kind == OP_SB)) begin
            bus_address    <= rs1_val + imm_s;
            // low byte of rs2 zero extended
            bus_write_data <= {{(`RV_XLEN - `RV_BYTE_W){1'b0}}, rs2_val[`RV_BYTE_W-1:0]};
        end
    end

endmodule

/* verif/rv_core_chk.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_chk import rv_pkg::*; (
    input logic  clk,
    input logic  reset,
    input addr_t pc,
    input logic  take,
    input logic  bus_write_enable
);

    // one sb gives exactly one strobe cycle
    property strobe_is_pulse;
        @(posedge clk) disable iff (!reset)
            bus_write_enable |=> !bus_write_enable;
    endproperty

    // fetch address stays on word boundaries
    property pc_word_aligned;
        @(posedge clk) disable iff (!reset)
            pc[1:0] == 2'b00;
    endproperty

    // entry redirects fetch to the handler on the same edge
    property entry_goes_to_handler;
        @(posedge clk) disable iff (!reset)
            take |=> (pc == `RV_TRAP_PC);
    endproperty

    a_strobe_pulse: assert property (strobe_is_pulse)
        else $error("bus_write_enable stayed high for two cycles");
    a_pc_aligned: assert property (pc_word_aligned)
        else $error("pc is not word aligned");
    a_entry_pc: assert property (entry_goes_to_handler)
        else $error("pc did not reach the handler after interrupt entry");

endmodule

/* verif/rv_core_tb.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int    WAIT_LIMIT = 200;
    localparam addr_t IMEM_BYTES = 32'd256;
    localparam addr_t BASE       = `RV_RESET_PC;

    logic     clk         = 1'b0;
    logic     reset       = 1'b0;
    logic     irq         = 1'b0;
    reg_idx_t dbg_idx     = '0;
    instr_t   instruction = NOP_WORD;
    addr_t    pc;
    word_t    bus_address;
    word_t    bus_write_data;
    logic     bus_write_enable;
    word_t    dbg_data;

    // program image with one word per 4 bytes
    instr_t imem [64];
    // bus writes seen since the last reset
    word_t  seen_addr [$];
    word_t  seen_data [$];

    rv_core u_rv_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .irq              (irq),
        .dbg_idx          (dbg_idx),
        .pc               (pc),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .dbg_data         (dbg_data)
    );

    bind rv_core rv_core_chk u_rv_core_chk (
        .clk              (clk),
        .reset            (reset),
        .pc               (pc),
        .take             (take),
        .bus_write_enable (bus_write_enable)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // fetch model answers from the current pc
    // outside the image everything reads as nop
    always @(negedge clk) begin
        instruction = (pc < IMEM_BYTES) ? imem[pc[7:2]] : NOP_WORD;
    end

    // bus monitor
    always @(posedge clk) begin
        if (!reset) begin
            seen_addr.delete();
            seen_data.delete();
        end else if (bus_write_enable) begin
            seen_addr.push_back(bus_address);
            seen_data.push_back(bus_write_data);
        end
    end

    // immediates as the ISA defines them
    function automatic word_t sext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic word_t lui_value(input logic [19:0] imm);
        return {{32{imm[19]}}, imm, 12'h000};
    endfunction

    // instruction encoders
    function automatic instr_t lui_word(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic instr_t addi_word(input reg_idx_t rd, input reg_idx_t rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_OPIMM};
    endfunction

    function automatic instr_t sb_word(input reg_idx_t rs2, input reg_idx_t rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OPC_STORE};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at first failing check");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act != exp) begin
            report_failure($sformatf("** Error at %0t ns: %s expected %h got %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act != exp) begin
            report_failure($sformatf("** Error at %0t ns: %s expected %h got %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("** Error at %0t ns: %s expected %0d got %0d",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_bus(input word_t exp_addr, input word_t exp_data,
                             input word_t act_addr, input word_t act_data);
        if ((act_addr != exp_addr) || (act_data != exp_data)) begin
            report_failure($sformatf(
                "** Error at %0t ns: bus_address/bus_write_data expected %h/%h got %h/%h",
                $time, exp_addr, exp_data, act_addr, act_data));
        end
    endtask

    // called at a falling edge where registers are settled
    task automatic read_reg(input reg_idx_t idx, output word_t val);
        dbg_idx = idx;
        #1;
        val = dbg_data;
    endtask

    task automatic wait_pc(input addr_t target);
        int n;
        n = 0;
        while (pc != target) begin
            if (n == WAIT_LIMIT) begin
                report_failure($sformatf("timeout, pc never reached %h", target));
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_bus(input int count);
        int n;
        n = 0;
        while (seen_addr.size() < count) begin
            if (n == WAIT_LIMIT) begin
                report_failure($sformatf("timeout, fewer than %0d bus writes seen", count));
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic put_word(input addr_t addr, input instr_t w);
        imem[addr[7:2]] = w;
    endtask

    // core held in reset while the image is rewritten
    task automatic enter_reset();
        @(negedge clk);
        reset = 1'b0;
        irq   = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP_WORD;
        end
    endtask

    task automatic leave_reset();
        repeat (10) @(negedge clk);
        reset = 1'b1;
    endtask

    task automatic test_lui();
        word_t got;
        enter_reset();
        put_word(BASE, lui_word(5'd1, 20'h12345));
        // bit 31 set so the upper half fills with ones
        put_word(BASE + 32'd4, lui_word(5'd2, 20'h80001));
        leave_reset();
        // nothing fetched yet
        check_addr("pc", `RV_RESET_PC, pc);
        check_word("bus_write_enable", '0, {63'd0, bus_write_enable});
        wait_pc(BASE + 32'd12);
        read_reg(5'd1, got);
        check_word("x1", lui_value(20'h12345), got);
        read_reg(5'd2, got);
        check_word("x2", lui_value(20'h80001), got);
    endtask

    task automatic test_addi_chain();
        logic [11:0] imms [4];
        word_t       sum;
        word_t       got;
        imms = '{12'hffb, 12'h064, 12'h800, 12'h7ff};
        sum  = '0;
        enter_reset();
        // each step adds onto the previous register
        for (int i = 0; i < 4; i++) begin
            put_word(BASE + 32'(4 * i), addi_word(reg_idx_t'(i + 1), reg_idx_t'(i), imms[i]));
        end
        // x0 target throws the result away
        put_word(BASE + 32'd16, addi_word(5'd0, 5'd4, 12'h001));
        leave_reset();
        wait_pc(BASE + 32'd24);
        for (int i = 0; i < 4; i++) begin
            sum = sum + sext12(imms[i]);
            read_reg(reg_idx_t'(i + 1), got);
            check_word($sformatf("x%0d", i + 1), sum, got);
        end
        read_reg(5'd0, got);
        check_word("x0", '0, got);
    endtask

    task automatic test_store();
        word_t base_val;
        word_t data_val;
        base_val = lui_value(20'h80000);
        data_val = sext12(12'h3a5);
        enter_reset();
        put_word(BASE, lui_word(5'd5, 20'h80000));
        put_word(BASE + 32'd4, addi_word(5'd6, 5'd0, 12'h3a5));
        put_word(BASE + 32'd8, sb_word(5'd6, 5'd5, 12'h123));
        leave_reset();
        wait_bus(1);
        // extra cycles so a second pulse would land in the queue
        wait_pc(BASE + 32'd32);
        check_count("bus writes", 1, seen_addr.size());
        check_bus(base_val + sext12(12'h123), {56'd0, data_val[7:0]},
                  seen_addr[0], seen_data[0]);
    endtask

    // 16 increments of x10 and a handler that prints one byte
    task automatic run_interrupt(input addr_t irq_at, input logic reraise);
        word_t got;
        word_t byte_val;
        addr_t resume_pc;
        // ir holds the word fetched one slot before irq_at
        resume_pc = irq_at - 32'd4;
        byte_val  = sext12(12'h04f);
        enter_reset();
        for (int k = 0; k < 16; k++) begin
            put_word(BASE + 32'(4 * k), addi_word(5'd10, 5'd10, 12'h001));
        end
        put_word(`RV_TRAP_PC, addi_word(5'd8, 5'd0, 12'h04f));
        put_word(`RV_TRAP_PC + 32'd4, sb_word(5'd8, 5'd0, 12'h100));
        put_word(`RV_TRAP_PC + 32'd12, MRET_WORD);
        leave_reset();
        wait_pc(irq_at);
        irq = 1'b1;
        @(negedge clk);
        check_addr("pc", `RV_TRAP_PC, pc);
        irq = 1'b0;
        // only words before resume_pc have run
        read_reg(5'd10, got);
        check_word("x10 at entry", {32'd0, (resume_pc - BASE) >> 2}, got);
        if (reraise) begin
            // level back up while in_handler is set
            wait_pc(`RV_TRAP_PC + 32'd8);
            irq = 1'b1;
            wait_pc(`RV_TRAP_PC + 32'd12);
            irq = 1'b0;
        end
        wait_pc(resume_pc);
        read_reg(5'd10, got);
        check_word("x10 at return", {32'd0, (resume_pc - BASE) >> 2}, got);
        wait_pc(BASE + 32'd72);
        read_reg(5'd10, got);
        check_word("x10", 64'd16, got);
        check_count("bus writes", 1, seen_addr.size());
        check_bus(sext12(12'h100), {56'd0, byte_val[7:0]}, seen_addr[0], seen_data[0]);
    endtask

    initial begin
        test_lui();
        test_addi_chain();
        test_store();
        // plain entry and return
        run_interrupt(BASE + 32'd16, 1'b0);
        // second request inside the handler
        run_interrupt(BASE + 32'd28, 1'b1);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+src
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_trap_unit.sv
src/rv_core.sv
verif/rv_core_chk.sv
verif/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module rv_core_tb -o rv_core_tb

./obj_dir/rv_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
else
    exit 1
fi
